/* alu_op_decode.sv */
// Picks the ALU and branch operations from funct3/funct7, covering mv,
// lui/auipc and the M extension. Flags mul/div when the unit is absent.
`timescale 1ns/10ps

module alu_op_decode #(
    parameter int HAS_MULDIV = 1
) (
    input  rv_decode_pkg::opcode_t    opcode,
    input  logic [2:0]                funct3,
    input  logic [6:0]                funct7,
    input  rv_decode_pkg::word_t      imm,
    output rv_decode_pkg::alu_op_e    alu_op,
    output rv_decode_pkg::branch_op_e branch_op,
    output logic                      op_illegal
);

    localparam int ALT_F7 = rv_decode_pkg::ALT_BIT - 25;  // ALT_BIT within funct7

    logic alt;
    logic muldiv_enc;

    assign alt        = funct7[ALT_F7];
    assign muldiv_enc = (opcode == rv_decode_pkg::OP_REG) &&
                        (funct7 == rv_decode_pkg::FUNCT7_MULDIV);
    assign op_illegal = muldiv_enc && (HAS_MULDIV == 0);

    always_comb begin
        alu_op    = rv_decode_pkg::ALU_ADD;
        branch_op = rv_decode_pkg::BRANCH_EQ;
        case (opcode)
            rv_decode_pkg::OP_IMM, rv_decode_pkg::OP_REG: begin
                case (funct3)
                    rv_decode_pkg::F3_ADD_SUB: begin
                        if (opcode == rv_decode_pkg::OP_IMM)
                            alu_op = (imm == '0) ? rv_decode_pkg::ALU_COPY_A
                                                 : rv_decode_pkg::ALU_ADD;
                        else if (alt)
                            alu_op = rv_decode_pkg::ALU_SUB;
                    end
                    rv_decode_pkg::F3_SLL:  alu_op = rv_decode_pkg::ALU_SLL;
                    rv_decode_pkg::F3_SLT:  alu_op = rv_decode_pkg::ALU_SLT;
                    rv_decode_pkg::F3_SLTU: alu_op = rv_decode_pkg::ALU_SLTU;
                    rv_decode_pkg::F3_XOR:  alu_op = rv_decode_pkg::ALU_XOR;
                    rv_decode_pkg::F3_SRL_SRA: begin
                        alu_op = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
                    end
                    rv_decode_pkg::F3_OR:   alu_op = rv_decode_pkg::ALU_OR;
                    rv_decode_pkg::F3_AND:  alu_op = rv_decode_pkg::ALU_AND;
                    default: ;
                endcase
                // M extension overrides the base op
                if (muldiv_enc && HAS_MULDIV != 0) begin
                    case (funct3)
                        3'b000:  alu_op = rv_decode_pkg::ALU_MUL;
                        3'b001:  alu_op = rv_decode_pkg::ALU_MULH;
                        3'b010:  alu_op = rv_decode_pkg::ALU_MULHSU;
                        3'b011:  alu_op = rv_decode_pkg::ALU_MULHU;
                        3'b100:  alu_op = rv_decode_pkg::ALU_DIV;
                        3'b101:  alu_op = rv_decode_pkg::ALU_DIVU;
                        3'b110:  alu_op = rv_decode_pkg::ALU_REM;
                        default: alu_op = rv_decode_pkg::ALU_REMU;
                    endcase
                end
            end
            rv_decode_pkg::OP_LUI: alu_op = rv_decode_pkg::ALU_COPY_B;
            rv_decode_pkg::OP_BRANCH: begin
                case (funct3)
                    rv_decode_pkg::F3_BNE:  branch_op = rv_decode_pkg::BRANCH_NE;
                    rv_decode_pkg::F3_BLT:  branch_op = rv_decode_pkg::BRANCH_LT;
                    rv_decode_pkg::F3_BGE:  branch_op = rv_decode_pkg::BRANCH_GE;
                    rv_decode_pkg::F3_BLTU: branch_op = rv_decode_pkg::BRANCH_LTU;
                    rv_decode_pkg::F3_BGEU: branch_op = rv_decode_pkg::BRANCH_GEU;
                    default:                branch_op = rv_decode_pkg::BRANCH_EQ;  // beq, reserved
                endcase
            end
            default: ;  // AUIPC adds, the rest use the defaults
        endcase
    end

endmodule

/* ctrl_decode.sv */
// Control decode: execution unit, register file enables and the
// load/store/branch/jump flags, all derived from the opcode.
`timescale 1ns/10ps

module ctrl_decode #(
    parameter int HAS_MULDIV = 1
) (
    input  rv_decode_pkg::opcode_t    opcode,
    input  logic [6:0]                funct7,
    input  rv_decode_pkg::reg_addr_t  rd,
    output rv_decode_pkg::exec_unit_e unit,
    output logic                      rs1_en,
    output logic                      rs2_en,
    output logic                      rd_en,
    output logic                      is_load,
    output logic                      is_store,
    output logic                      is_branch,
    output logic                      is_jump
);

    logic muldiv_sel;
    logic rd_nonzero;

    assign muldiv_sel = (HAS_MULDIV != 0) && (funct7 == rv_decode_pkg::FUNCT7_MULDIV);
    assign rd_nonzero = (rd != '0);  // j and ret write no link register

    always_comb begin
        unit      = rv_decode_pkg::UNIT_NONE;
        rs1_en    = 1'b0;
        rs2_en    = 1'b0;
        rd_en     = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            rv_decode_pkg::OP_IMM: begin
                unit   = rv_decode_pkg::UNIT_ALU;
                rs1_en = 1'b1;
                rd_en  = 1'b1;
            end
            rv_decode_pkg::OP_REG: begin
                unit   = muldiv_sel ? rv_decode_pkg::UNIT_MULDIV : rv_decode_pkg::UNIT_ALU;
                rs1_en = 1'b1;
                rs2_en = 1'b1;
                rd_en  = 1'b1;
            end
            rv_decode_pkg::OP_LOAD: begin
                unit    = rv_decode_pkg::UNIT_LOAD;
                rs1_en  = 1'b1;
                rd_en   = 1'b1;
                is_load = 1'b1;
            end
            rv_decode_pkg::OP_STORE: begin
                unit     = rv_decode_pkg::UNIT_STORE;
                rs1_en   = 1'b1;
                rs2_en   = 1'b1;
                is_store = 1'b1;
            end
            rv_decode_pkg::OP_BRANCH: begin
                unit      = rv_decode_pkg::UNIT_BRANCH;
                rs1_en    = 1'b1;
                rs2_en    = 1'b1;
                is_branch = 1'b1;
            end
            rv_decode_pkg::OP_JAL, rv_decode_pkg::OP_JALR: begin
                unit    = rv_decode_pkg::UNIT_BRANCH;
                rs1_en  = (opcode == rv_decode_pkg::OP_JALR);
                rd_en   = rd_nonzero;
                is_jump = 1'b1;
            end
            rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC: begin
                unit  = rv_decode_pkg::UNIT_ALU;
                rd_en = 1'b1;
            end
            default: ;  // Unsupported, everything stays cleared
        endcase
    end

endmodule

/* decode_stage.sv */
// Single-stage RV32IM decoder top. Slices the instruction, runs the
// combinational decoders and registers all outputs one cycle later.
`timescale 1ns/10ps

module decode_stage #(
    parameter int HAS_MULDIV = 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_in,
    input  rv_decode_pkg::word_t      pc_in,
    input  rv_decode_pkg::word_t      instruction_in,
    output logic                      dec_valid,
    output rv_decode_pkg::word_t      dec_pc,
    output rv_decode_pkg::reg_addr_t  dec_rs1,
    output rv_decode_pkg::reg_addr_t  dec_rs2,
    output rv_decode_pkg::reg_addr_t  dec_rd,
    output logic                      dec_rs1_en,
    output logic                      dec_rs2_en,
    output logic                      dec_rd_en,
    output rv_decode_pkg::word_t      dec_imm,
    output rv_decode_pkg::inst_format_e dec_format,
    output rv_decode_pkg::exec_unit_e dec_unit,
    output rv_decode_pkg::alu_op_e    dec_alu_op,
    output rv_decode_pkg::branch_op_e dec_branch_op,
    output logic                      dec_is_load,
    output logic                      dec_is_store,
    output logic                      dec_is_branch,
    output logic                      dec_is_jump
);

    rv_decode_pkg::opcode_t      opcode;
    rv_decode_pkg::reg_addr_t    rd, rs1, rs2;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;

    rv_decode_pkg::inst_format_e format;
    logic                        opcode_illegal;
    rv_decode_pkg::word_t        imm;
    rv_decode_pkg::exec_unit_e   unit;
    logic                        rs1_en, rs2_en, rd_en;
    logic                        is_load, is_store, is_branch, is_jump;
    rv_decode_pkg::alu_op_e      alu_op;
    rv_decode_pkg::branch_op_e   branch_op;
    logic                        op_illegal;
    logic                        legal;

    assign opcode = instruction_in[6:0];
    assign rd     = instruction_in[11:7];
    assign funct3 = instruction_in[14:12];
    assign rs1    = instruction_in[19:15];
    assign rs2    = instruction_in[24:20];
    assign funct7 = instruction_in[31:25];

    format_decode i_format_decode (
        .opcode         (opcode),
        .format         (format),
        .opcode_illegal (opcode_illegal)
    );

    imm_gen i_imm_gen (
        .instruction (instruction_in),
        .format      (format),
        .imm         (imm)
    );

    ctrl_decode #(.HAS_MULDIV(HAS_MULDIV)) i_ctrl_decode (
        .opcode    (opcode),
        .funct7    (funct7),
        .rd        (rd),
        .unit      (unit),
        .rs1_en    (rs1_en),
        .rs2_en    (rs2_en),
        .rd_en     (rd_en),
        .is_load   (is_load),
        .is_store  (is_store),
        .is_branch (is_branch),
        .is_jump   (is_jump)
    );

    alu_op_decode #(.HAS_MULDIV(HAS_MULDIV)) i_alu_op_decode (
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .imm        (imm),
        .alu_op     (alu_op),
        .branch_op  (branch_op),
        .op_illegal (op_illegal)
    );

    assign legal = valid_in && !opcode_illegal && !op_illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid     <= 1'b0;
            dec_pc        <= '0;
            dec_rs1       <= '0;
            dec_rs2       <= '0;
            dec_rd        <= '0;
            dec_imm       <= '0;
            dec_format    <= rv_decode_pkg::FMT_NONE;
            dec_rs1_en    <= 1'b0;
            dec_rs2_en    <= 1'b0;
            dec_rd_en     <= 1'b0;
            dec_unit      <= rv_decode_pkg::UNIT_NONE;
            dec_alu_op    <= rv_decode_pkg::ALU_ADD;
            dec_branch_op <= rv_decode_pkg::BRANCH_EQ;
            dec_is_load   <= 1'b0;
            dec_is_store  <= 1'b0;
            dec_is_branch <= 1'b0;
            dec_is_jump   <= 1'b0;
        end else begin
            // Fields captured on every cycle
            dec_pc     <= pc_in;
            dec_rs1    <= rs1;
            dec_rs2    <= rs2;
            dec_rd     <= rd;
            dec_imm    <= imm;
            dec_format <= format;
            // Control masked unless a legal instruction is presented
            dec_valid     <= legal;
            dec_rs1_en    <= legal && rs1_en;
            dec_rs2_en    <= legal && rs2_en;
            dec_rd_en     <= legal && rd_en;
            dec_unit      <= legal ? unit : rv_decode_pkg::UNIT_NONE;
            dec_alu_op    <= legal ? alu_op : rv_decode_pkg::ALU_ADD;
            dec_branch_op <= legal ? branch_op : rv_decode_pkg::BRANCH_EQ;
            dec_is_load   <= legal && is_load;
            dec_is_store  <= legal && is_store;
            dec_is_branch <= legal && is_branch;
            dec_is_jump   <= legal && is_jump;
        end
    end

endmodule

/* flist.f */
+incdir+.
rv_decode_pkg.sv
imm_gen.sv
format_decode.sv
ctrl_decode.sv
alu_op_decode.sv
decode_stage.sv
tb_decode_stage.sv

/* format_decode.sv */
// Classifies an opcode into its instruction format.
// Opcodes outside RV32IM give FMT_NONE and raise opcode_illegal.
`timescale 1ns/10ps

module format_decode (
    input  rv_decode_pkg::opcode_t      opcode,
    output rv_decode_pkg::inst_format_e format,
    output logic                        opcode_illegal
);

    always_comb begin
        opcode_illegal = 1'b0;
        case (opcode)
            rv_decode_pkg::OP_REG: begin
                format = rv_decode_pkg::FMT_R;
            end
            rv_decode_pkg::OP_LOAD,
            rv_decode_pkg::OP_IMM,
            rv_decode_pkg::OP_JALR: begin
                format = rv_decode_pkg::FMT_I;
            end
            rv_decode_pkg::OP_STORE: begin
                format = rv_decode_pkg::FMT_S;
            end
            rv_decode_pkg::OP_BRANCH: begin
                format = rv_decode_pkg::FMT_B;
            end
            rv_decode_pkg::OP_LUI,
            rv_decode_pkg::OP_AUIPC: begin
                format = rv_decode_pkg::FMT_U;
            end
            rv_decode_pkg::OP_JAL: begin
                format = rv_decode_pkg::FMT_J;
            end
            default: begin
                // SYSTEM, FP and custom opcodes land here
                format         = rv_decode_pkg::FMT_NONE;
                opcode_illegal = 1'b1;
            end
        endcase
    end

endmodule

/* imm_gen.sv */
// Immediate generator: gathers the scattered immediate bits of each format
// and sign-extends them to 32 bits. Purely combinational.
`timescale 1ns/10ps

module imm_gen (
    input  rv_decode_pkg::word_t        instruction,
    input  rv_decode_pkg::inst_format_e format,
    output rv_decode_pkg::word_t        imm
);

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (format)
            rv_decode_pkg::FMT_I: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            rv_decode_pkg::FMT_S: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            rv_decode_pkg::FMT_B: begin
                // Halfword aligned branch offset
                imm = {{19{sign}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            rv_decode_pkg::FMT_U: begin
                imm = {instruction[31:12], 12'b0};
            end
            rv_decode_pkg::FMT_J: begin
                imm = {{11{sign}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // R format and unsupported opcodes
            end
        endcase
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the decoder testbench with Verilator, M extension on and off
cd "$(dirname "$0")" || exit 1
status=0
for md in 1 0; do
    obj="obj_dir_md${md}"
    log="sim_md${md}.log"
    rm -f "$log"
    verilator --binary --timing -f flist.f --top-module tb_decode_stage \
        -GHAS_MULDIV=${md} --Mdir "$obj" -o tb_sim \
        && "./${obj}/tb_sim" | tee "$log" \
        || echo "Build or run failed for HAS_MULDIV=${md}"
    grep -qx "Done: no errors" "$log" && echo "HAS_MULDIV=${md} passed" \
        || { echo "HAS_MULDIV=${md} failed"; status=1; }
done
exit $status

/* rv_decode_pkg.sv */
// Shared widths, opcode and funct encodings and enums for the RV32IM decoder.
// Design and testbench refer to these by scoped name.
package rv_decode_pkg;

    typedef logic [31:0] word_t;      // Instruction, PC or immediate
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Base opcodes
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // funct3 for OP_IMM and OP_REG
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    localparam int         ALT_BIT       = 30;  // SUB / SRA select

    // Zero encodings double as the reset and idle values
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } inst_format_e;

    typedef enum logic [2:0] {
        UNIT_NONE   = 3'd0,
        UNIT_ALU    = 3'd1,
        UNIT_MULDIV = 3'd2,
        UNIT_LOAD   = 3'd3,
        UNIT_STORE  = 3'd4,
        UNIT_BRANCH = 3'd5
    } exec_unit_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_COPY_A,  // mv, passes rs1
        ALU_COPY_B,  // lui, passes the immediate
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [2:0] {
        BRANCH_EQ, BRANCH_NE, BRANCH_LT, BRANCH_GE, BRANCH_LTU, BRANCH_GEU
    } branch_op_e;

endpackage

/* tb_decode_model.svh */
// Reference model for the RV32IM decode stage, included inside the testbench module.
// Predicts every registered field of one instruction from the ISA encoding rules.
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

function automatic rv_decode_pkg::inst_format_e model_format(input rv_decode_pkg::opcode_t op);
    case (op)
        rv_decode_pkg::OP_REG:    return rv_decode_pkg::FMT_R;
        rv_decode_pkg::OP_LOAD,
        rv_decode_pkg::OP_IMM,
        rv_decode_pkg::OP_JALR:   return rv_decode_pkg::FMT_I;
        rv_decode_pkg::OP_STORE:  return rv_decode_pkg::FMT_S;
        rv_decode_pkg::OP_BRANCH: return rv_decode_pkg::FMT_B;
        rv_decode_pkg::OP_LUI,
        rv_decode_pkg::OP_AUIPC:  return rv_decode_pkg::FMT_U;
        rv_decode_pkg::OP_JAL:    return rv_decode_pkg::FMT_J;
        default:                  return rv_decode_pkg::FMT_NONE;
    endcase
endfunction

function automatic rv_decode_pkg::word_t model_imm(input rv_decode_pkg::word_t inst);
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;
    s_imm = {inst[31:25], inst[11:7]};
    b_imm = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    j_imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    case (model_format(inst[6:0]))
        rv_decode_pkg::FMT_I: return {{20{inst[31]}}, inst[31:20]};
        rv_decode_pkg::FMT_S: return {{20{s_imm[11]}}, s_imm};
        rv_decode_pkg::FMT_B: return {{19{b_imm[12]}}, b_imm};
        rv_decode_pkg::FMT_U: return {inst[31:12], 12'h000};
        rv_decode_pkg::FMT_J: return {{11{j_imm[20]}}, j_imm};
        default:              return 32'h0;
    endcase
endfunction

function automatic logic model_is_muldiv(input rv_decode_pkg::word_t inst);
    return (inst[6:0] == rv_decode_pkg::OP_REG) && (inst[31:25] == rv_decode_pkg::FUNCT7_MULDIV);
endfunction

// Decoded instruction survives the output mask
function automatic logic model_legal(input logic valid, input rv_decode_pkg::word_t inst,
                                     input int has_md);
    if (!valid || model_format(inst[6:0]) == rv_decode_pkg::FMT_NONE)
        return 1'b0;
    return !(model_is_muldiv(inst) && has_md == 0);
endfunction

// {rs1_en, rs2_en, rd_en, is_load, is_store, is_branch, is_jump}
function automatic logic [6:0] model_ctrl(input rv_decode_pkg::word_t inst);
    logic link;
    link = (inst[11:7] != 5'd0);
    case (inst[6:0])
        rv_decode_pkg::OP_IMM:    return 7'b101_0000;
        rv_decode_pkg::OP_REG:    return 7'b111_0000;
        rv_decode_pkg::OP_LOAD:   return 7'b101_1000;
        rv_decode_pkg::OP_STORE:  return 7'b110_0100;
        rv_decode_pkg::OP_BRANCH: return 7'b110_0010;
        rv_decode_pkg::OP_JAL:    return {2'b00, link, 4'b0001};
        rv_decode_pkg::OP_JALR:   return {2'b10, link, 4'b0001};
        rv_decode_pkg::OP_LUI,
        rv_decode_pkg::OP_AUIPC:  return 7'b001_0000;
        default:                  return 7'b000_0000;
    endcase
endfunction

function automatic rv_decode_pkg::exec_unit_e model_unit(input rv_decode_pkg::word_t inst,
                                                         input int has_md);
    case (inst[6:0])
        rv_decode_pkg::OP_IMM, rv_decode_pkg::OP_LUI,
        rv_decode_pkg::OP_AUIPC:  return rv_decode_pkg::UNIT_ALU;
        rv_decode_pkg::OP_REG:
            return (model_is_muldiv(inst) && has_md != 0) ? rv_decode_pkg::UNIT_MULDIV
                                                          : rv_decode_pkg::UNIT_ALU;
        rv_decode_pkg::OP_LOAD:   return rv_decode_pkg::UNIT_LOAD;
        rv_decode_pkg::OP_STORE:  return rv_decode_pkg::UNIT_STORE;
        rv_decode_pkg::OP_BRANCH, rv_decode_pkg::OP_JAL,
        rv_decode_pkg::OP_JALR:   return rv_decode_pkg::UNIT_BRANCH;
        default:                  return rv_decode_pkg::UNIT_NONE;
    endcase
endfunction

function automatic rv_decode_pkg::alu_op_e base_alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
        3'd1:    return rv_decode_pkg::ALU_SLL;
        3'd2:    return rv_decode_pkg::ALU_SLT;
        3'd3:    return rv_decode_pkg::ALU_SLTU;
        3'd4:    return rv_decode_pkg::ALU_XOR;
        3'd5:    return alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
        3'd6:    return rv_decode_pkg::ALU_OR;
        default: return rv_decode_pkg::ALU_AND;
    endcase
endfunction

function automatic rv_decode_pkg::alu_op_e model_alu_op(input rv_decode_pkg::word_t inst,
                                                        input int has_md);
    logic [2:0] f3;
    logic       alt;
    f3  = inst[14:12];
    alt = inst[rv_decode_pkg::ALT_BIT];
    case (inst[6:0])
        rv_decode_pkg::OP_IMM: begin
            if (f3 == 3'd0)  // addi, or mv with a zero immediate
                return (inst[31:20] == 12'd0) ? rv_decode_pkg::ALU_COPY_A : rv_decode_pkg::ALU_ADD;
            return base_alu_op(f3, alt);
        end
        rv_decode_pkg::OP_REG: begin
            if (model_is_muldiv(inst) && has_md != 0)
                return rv_decode_pkg::alu_op_e'(5'(int'(rv_decode_pkg::ALU_MUL) + int'(f3)));
            return base_alu_op(f3, alt);
        end
        rv_decode_pkg::OP_LUI: return rv_decode_pkg::ALU_COPY_B;
        default:               return rv_decode_pkg::ALU_ADD;
    endcase
endfunction

function automatic rv_decode_pkg::branch_op_e model_branch_op(input rv_decode_pkg::word_t inst);
    if (inst[6:0] != rv_decode_pkg::OP_BRANCH)
        return rv_decode_pkg::BRANCH_EQ;
    case (inst[14:12])
        3'd1:    return rv_decode_pkg::BRANCH_NE;
        3'd4:    return rv_decode_pkg::BRANCH_LT;
        3'd5:    return rv_decode_pkg::BRANCH_GE;
        3'd6:    return rv_decode_pkg::BRANCH_LTU;
        3'd7:    return rv_decode_pkg::BRANCH_GEU;
        default: return rv_decode_pkg::BRANCH_EQ;  // beq and reserved codes
    endcase
endfunction

`endif

/* tb_decode_stage.sv */
// Testbench for decode_stage: random instructions from a fixed seed, each
// checked one cycle later against the model in tb_decode_model.svh.
`timescale 1ns/10ps

module tb_decode_stage #(
    parameter int HAS_MULDIV = 1
);

    localparam int          NUM_TESTS  = 3000;
    localparam int          TIMEOUT_NS = (NUM_TESTS + 20) * 10;
    localparam int unsigned SEED       = 32'hc2bd86aa;

    logic clk = 1'b0;
    logic rst;
    logic valid_in;
    rv_decode_pkg::word_t pc_in;
    rv_decode_pkg::word_t instruction_in;

    logic                        dec_valid;
    rv_decode_pkg::word_t        dec_pc;
    rv_decode_pkg::reg_addr_t    dec_rs1, dec_rs2, dec_rd;
    logic                        dec_rs1_en, dec_rs2_en, dec_rd_en;
    rv_decode_pkg::word_t        dec_imm;
    rv_decode_pkg::inst_format_e dec_format;
    rv_decode_pkg::exec_unit_e   dec_unit;
    rv_decode_pkg::alu_op_e      dec_alu_op;
    rv_decode_pkg::branch_op_e   dec_branch_op;
    logic                        dec_is_load, dec_is_store, dec_is_branch, dec_is_jump;

    logic [64:0] expect_q[$];  // {valid, pc, instruction} captured at each edge
    int          errors = 0;
    int          checks = 0;
    int          legal_seen = 0;

    `include "tb_decode_model.svh"

    always #5 clk = ~clk;

    decode_stage #(.HAS_MULDIV(HAS_MULDIV)) i_decode_stage (
        .clk            (clk),
        .rst            (rst),
        .valid_in       (valid_in),
        .pc_in          (pc_in),
        .instruction_in (instruction_in),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_rd         (dec_rd),
        .dec_rs1_en     (dec_rs1_en),
        .dec_rs2_en     (dec_rs2_en),
        .dec_rd_en      (dec_rd_en),
        .dec_imm        (dec_imm),
        .dec_format     (dec_format),
        .dec_unit       (dec_unit),
        .dec_alu_op     (dec_alu_op),
        .dec_branch_op  (dec_branch_op),
        .dec_is_load    (dec_is_load),
        .dec_is_store   (dec_is_store),
        .dec_is_branch  (dec_is_branch),
        .dec_is_jump    (dec_is_jump)
    );

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_quiet(input string when);
        check_value({when, " dec_valid"}, 32'(dec_valid), 32'd0);
        check_value({when, " enables"}, 32'({dec_rs1_en, dec_rs2_en, dec_rd_en}), 32'd0);
        check_value({when, " flags"},
                    32'({dec_is_load, dec_is_store, dec_is_branch, dec_is_jump}), 32'd0);
    endtask

    task automatic check_item(input logic [64:0] item);
        logic                 valid;
        rv_decode_pkg::word_t pc;
        rv_decode_pkg::word_t inst;
        logic                 legal;
        logic [6:0]           ctrl;
        string                ctx;
        valid = item[64];
        pc    = item[63:32];
        inst  = item[31:0];
        legal = model_legal(valid, inst, HAS_MULDIV);
        ctrl  = legal ? model_ctrl(inst) : 7'd0;
        ctx   = $sformatf("inst %h valid %0d:", inst, valid);
        if (legal)
            legal_seen++;
        check_value({ctx, " dec_valid"}, 32'(dec_valid), 32'(legal));
        check_value({ctx, " dec_pc"}, dec_pc, pc);
        check_value({ctx, " dec_rs1"}, 32'(dec_rs1), 32'(inst[19:15]));
        check_value({ctx, " dec_rs2"}, 32'(dec_rs2), 32'(inst[24:20]));
        check_value({ctx, " dec_rd"}, 32'(dec_rd), 32'(inst[11:7]));
        check_value({ctx, " dec_imm"}, dec_imm, model_imm(inst));
        check_value({ctx, " dec_format"}, 32'(dec_format), 32'(model_format(inst[6:0])));
        check_value({ctx, " enables and flags"},
                    32'({dec_rs1_en, dec_rs2_en, dec_rd_en, dec_is_load, dec_is_store,
                         dec_is_branch, dec_is_jump}), 32'(ctrl));
        check_value({ctx, " dec_unit"}, 32'(dec_unit),
                    32'(legal ? model_unit(inst, HAS_MULDIV) : rv_decode_pkg::UNIT_NONE));
        check_value({ctx, " dec_alu_op"}, 32'(dec_alu_op),
                    32'(legal ? model_alu_op(inst, HAS_MULDIV) : rv_decode_pkg::ALU_ADD));
        check_value({ctx, " dec_branch_op"}, 32'(dec_branch_op),
                    32'(legal ? model_branch_op(inst) : rv_decode_pkg::BRANCH_EQ));
    endtask

    function automatic rv_decode_pkg::opcode_t supported_opcode(input int unsigned idx);
        case (idx)
            0:       return rv_decode_pkg::OP_LOAD;
            1:       return rv_decode_pkg::OP_STORE;
            2:       return rv_decode_pkg::OP_BRANCH;
            3:       return rv_decode_pkg::OP_JAL;
            4:       return rv_decode_pkg::OP_JALR;
            5:       return rv_decode_pkg::OP_IMM;
            6:       return rv_decode_pkg::OP_REG;
            7:       return rv_decode_pkg::OP_LUI;
            default: return rv_decode_pkg::OP_AUIPC;
        endcase
    endfunction

    function automatic rv_decode_pkg::word_t random_instruction();
        rv_decode_pkg::word_t inst;
        inst = $urandom();
        if ($urandom_range(0, 7) != 0)
            inst[6:0] = supported_opcode($urandom_range(0, 8));  // else raw opcode bits
        if ($urandom_range(0, 3) == 0)
            inst[31:25] = rv_decode_pkg::FUNCT7_MULDIV;
        if ($urandom_range(0, 7) == 0)
            inst[31:20] = 12'd0;  // Turns addi into mv
        if ($urandom_range(0, 5) == 0)
            inst[11:7] = 5'd0;
        return inst;
    endfunction

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (expect_q.size() > 0)
            check_item(expect_q.pop_front());
    end

    initial begin : stimulus
        int unsigned seed_ret;
        seed_ret       = $urandom(SEED);
        rst            = 1'b1;
        valid_in       = 1'b0;
        pc_in          = '0;
        instruction_in = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_quiet("In reset");
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_quiet("After reset");
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            expect_q.push_back({valid_in, pc_in, instruction_in});  // Captured at this edge
            valid_in       <= ($urandom_range(0, 7) != 0);
            pc_in          <= $urandom();
            instruction_in <= random_instruction();
        end
        @(posedge clk);
        expect_q.push_back({valid_in, pc_in, instruction_in});
        valid_in <= 1'b0;
        @(posedge clk);  // Last item already checked at the falling edge before
        $display("Checks: %0d, legal items: %0d, errors: %0d", checks, legal_seen, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule
